/* project.f */
src/rr_pkg.sv
src/rr_csrs.sv
src/rr_channel_tap.sv
src/rr_log_merge.sv
src/rr_replay_decoder.sv
src/rr_fpgarr_top.sv
tests/rr_fpgarr_asserts.sv
tests/tb_rr_fpgarr.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the testbench; a $fatal gives a failing exit status
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module tb_rr_fpgarr -f project.f -o sim_tb_rr_fpgarr

./obj_dir/sim_tb_rr_fpgarr

/* src/rr_channel_tap.sv */
module rr_channel_tap #(
  parameter rr_pkg::chan_t CHAN = '0
) (
  input  logic                      clk,
  input  logic                      i_rst,
  input  logic                      i_mode_record,
  input  logic                      i_mode_replay,
  input  logic                      i_sh_valid,
  input  logic [rr_pkg::ADDR_W-1:0] i_sh_addr,
  input  logic [rr_pkg::DATA_W-1:0] i_sh_data,
  input  logic                      i_rep_valid,
  input  logic [rr_pkg::ADDR_W-1:0] i_rep_addr,
  input  logic [rr_pkg::DATA_W-1:0] i_rep_data,
  input  logic                      i_pop,
  output logic                      o_cl_valid,
  output logic [rr_pkg::ADDR_W-1:0] o_cl_addr,
  output logic [rr_pkg::DATA_W-1:0] o_cl_data,
  output logic                      o_empty,
  output rr_pkg::log_entry_t        o_head,
  output logic                      o_overflow
);

  // Selected source, shell or replay
  logic                      sel_valid;
  logic [rr_pkg::ADDR_W-1:0] sel_addr;
  logic [rr_pkg::DATA_W-1:0] sel_data;
  // Log FIFO
  rr_pkg::log_entry_t fifo_mem [rr_pkg::LOG_FIFO_DEPTH];
  logic [$clog2(rr_pkg::LOG_FIFO_DEPTH)-1:0] wr_ptr;
  logic [$clog2(rr_pkg::LOG_FIFO_DEPTH)-1:0] rd_ptr;
  logic [$clog2(rr_pkg::LOG_FIFO_DEPTH+1)-1:0] fifo_cnt;
  logic fifo_full;
  logic push;
  logic push_ok;
  logic do_pop;

  // Unselected source is simply ignored
  assign sel_valid = i_mode_replay ? i_rep_valid : i_sh_valid;
  assign sel_addr  = i_mode_replay ? i_rep_addr  : i_sh_addr;
  assign sel_data  = i_mode_replay ? i_rep_data  : i_sh_data;

  //////////////////////////////////////////////////////////////
  // Output register toward the logic
  //////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_cl_valid <= 1'b0;
    end else begin
      o_cl_valid <= sel_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (sel_valid) begin
      o_cl_addr <= sel_addr;
      o_cl_data <= sel_data;
    end
  end

  //////////////////////////////////////////////////////////////
  // Log FIFO
  //////////////////////////////////////////////////////////////

  // Log exactly what gets forwarded, in the same cycle
  assign push      = i_mode_record && sel_valid;
  assign o_empty   = (fifo_cnt == '0);
  assign fifo_full = (fifo_cnt == rr_pkg::LOG_FIFO_DEPTH);
  assign do_pop    = i_pop && !o_empty;
  // A pop frees a slot on the same edge
  assign push_ok    = push && (!fifo_full || do_pop);
  assign o_overflow = push && !push_ok;
  assign o_head     = fifo_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (i_rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fifo_cnt <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr <= (wr_ptr == rr_pkg::LOG_FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == rr_pkg::LOG_FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      case ({push_ok, do_pop})
        2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
        2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
        default: fifo_cnt <= fifo_cnt;
      endcase
    end
  end

  // Entry tagged with this tap's channel
  always_ff @(posedge clk) begin
    if (push_ok) begin
      fifo_mem[wr_ptr] <= '{chan: CHAN, addr: sel_addr, data: sel_data};
    end
  end

endmodule

/* src/rr_csrs.sv */
module rr_csrs (
  input  logic                      clk,
  input  logic                      i_rst,
  input  logic                      i_cfg_wr,
  input  logic                      i_cfg_rd,
  input  logic [3:0]                i_cfg_addr,
  input  logic [rr_pkg::DATA_W-1:0] i_cfg_wdata,
  input  logic [rr_pkg::NUM_CHANNELS-1:0] i_overflow,
  input  logic                      i_rec_valid,
  output logic                      o_cfg_rvalid,
  output logic [rr_pkg::DATA_W-1:0] o_cfg_rdata,
  output logic                      o_mode_record,
  output logic                      o_mode_replay
);

  // Mode register as written by the host
  logic mode_record_q;
  logic mode_replay_q;
  // Delayed copies that fan out to the taps
  logic [rr_pkg::MODE_PIPE_STAGES-1:0] record_pipe;
  logic [rr_pkg::MODE_PIPE_STAGES-1:0] replay_pipe;
  logic [rr_pkg::NUM_CHANNELS-1:0] ovf_flags;
  logic [rr_pkg::DATA_W-1:0] rec_count;
  logic [rr_pkg::DATA_W-1:0] rd_mux;
  logic wr_mode;
  logic wr_status;

  assign wr_mode   = i_cfg_wr && (i_cfg_addr == rr_pkg::CFG_MODE_ADDR);
  assign wr_status = i_cfg_wr && (i_cfg_addr == rr_pkg::CFG_STATUS_ADDR);

  //////////////////////////////////////////////////////////////
  // Control registers
  //////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (i_rst) begin
      mode_record_q <= 1'b0;
      mode_replay_q <= 1'b0;
      record_pipe   <= '0;
      replay_pipe   <= '0;
      ovf_flags     <= '0;
      rec_count     <= '0;
      o_cfg_rvalid  <= 1'b0;
    end else begin
      if (wr_mode) begin
        mode_record_q <= i_cfg_wdata[rr_pkg::MODE_RECORD_BIT];
        mode_replay_q <= i_cfg_wdata[rr_pkg::MODE_REPLAY_BIT];
      end
      // Same depth on both bits so every tap switches on one edge
      record_pipe <= {record_pipe[rr_pkg::MODE_PIPE_STAGES-2:0], mode_record_q};
      replay_pipe <= {replay_pipe[rr_pkg::MODE_PIPE_STAGES-2:0], mode_replay_q};
      // Clear wins over old flags, a drop in the clear cycle still sticks
      ovf_flags <= (wr_status ? '0 : ovf_flags) | i_overflow;
      if (i_rec_valid) begin
        rec_count <= rec_count + 1'b1;
      end
      o_cfg_rvalid <= i_cfg_rd;
    end
  end

  assign o_mode_record = record_pipe[rr_pkg::MODE_PIPE_STAGES-1];
  assign o_mode_replay = replay_pipe[rr_pkg::MODE_PIPE_STAGES-1];

  //////////////////////////////////////////////////////////////
  // Read port
  //////////////////////////////////////////////////////////////

  always_comb begin
    rd_mux = '0;
    case (i_cfg_addr)
      rr_pkg::CFG_MODE_ADDR: begin
        rd_mux[rr_pkg::MODE_RECORD_BIT] = mode_record_q;
        rd_mux[rr_pkg::MODE_REPLAY_BIT] = mode_replay_q;
      end
      rr_pkg::CFG_STATUS_ADDR: rd_mux[rr_pkg::NUM_CHANNELS-1:0] = ovf_flags;
      rr_pkg::CFG_COUNT_ADDR:  rd_mux = rec_count;
      default:                 rd_mux = '0;
    endcase
  end

  // Data lands together with o_cfg_rvalid, one cycle after the request
  always_ff @(posedge clk) begin
    if (i_cfg_rd) begin
      o_cfg_rdata <= rd_mux;
    end
  end

endmodule

/* src/rr_fpgarr_top.sv */
module rr_fpgarr_top (
  input  logic                                            clk,
  input  logic                                            i_rst,
  // Shell side
  input  logic [rr_pkg::NUM_CHANNELS-1:0]                 i_sh_valid,
  input  logic [rr_pkg::NUM_CHANNELS-1:0][rr_pkg::ADDR_W-1:0] i_sh_addr,
  input  logic [rr_pkg::NUM_CHANNELS-1:0][rr_pkg::DATA_W-1:0] i_sh_data,
  // Custom logic side
  output logic [rr_pkg::NUM_CHANNELS-1:0]                 o_cl_valid,
  output logic [rr_pkg::NUM_CHANNELS-1:0][rr_pkg::ADDR_W-1:0] o_cl_addr,
  output logic [rr_pkg::NUM_CHANNELS-1:0][rr_pkg::DATA_W-1:0] o_cl_data,
  // Record and replay streams
  output logic                                            o_rec_valid,
  output rr_pkg::log_entry_t                              o_rec_entry,
  input  logic                                            i_rep_valid,
  input  rr_pkg::log_entry_t                              i_rep_entry,
  // Configuration port
  input  logic                                            i_cfg_wr,
  input  logic                                            i_cfg_rd,
  input  logic [3:0]                                      i_cfg_addr,
  input  logic [rr_pkg::DATA_W-1:0]                       i_cfg_wdata,
  output logic                                            o_cfg_rvalid,
  output logic [rr_pkg::DATA_W-1:0]                       o_cfg_rdata
);

  // Pipelined mode levels
  logic mode_record;
  logic mode_replay;
  // Tap to merge
  logic [rr_pkg::NUM_CHANNELS-1:0] fifo_empty;
  rr_pkg::log_entry_t [rr_pkg::NUM_CHANNELS-1:0] fifo_head;
  logic [rr_pkg::NUM_CHANNELS-1:0] pop;
  logic [rr_pkg::NUM_CHANNELS-1:0] overflow;
  // Decoder to taps
  logic [rr_pkg::NUM_CHANNELS-1:0] rep_valid;
  logic [rr_pkg::NUM_CHANNELS-1:0][rr_pkg::ADDR_W-1:0] rep_addr;
  logic [rr_pkg::NUM_CHANNELS-1:0][rr_pkg::DATA_W-1:0] rep_data;

  rr_csrs csrs (
    .clk(clk), .i_rst(i_rst),
    .i_cfg_wr(i_cfg_wr), .i_cfg_rd(i_cfg_rd),
    .i_cfg_addr(i_cfg_addr), .i_cfg_wdata(i_cfg_wdata),
    .i_overflow(overflow), .i_rec_valid(o_rec_valid),
    .o_cfg_rvalid(o_cfg_rvalid), .o_cfg_rdata(o_cfg_rdata),
    .o_mode_record(mode_record), .o_mode_replay(mode_replay)
  );

  //////////////////////////////////////////////////////////////
  // Channel taps, sda ocl bar1
  //////////////////////////////////////////////////////////////

  rr_channel_tap #(.CHAN(2'd0)) tap_sda (
    .clk(clk), .i_rst(i_rst),
    .i_mode_record(mode_record), .i_mode_replay(mode_replay),
    .i_sh_valid(i_sh_valid[0]), .i_sh_addr(i_sh_addr[0]), .i_sh_data(i_sh_data[0]),
    .i_rep_valid(rep_valid[0]), .i_rep_addr(rep_addr[0]), .i_rep_data(rep_data[0]),
    .i_pop(pop[0]),
    .o_cl_valid(o_cl_valid[0]), .o_cl_addr(o_cl_addr[0]), .o_cl_data(o_cl_data[0]),
    .o_empty(fifo_empty[0]), .o_head(fifo_head[0]), .o_overflow(overflow[0])
  );

  rr_channel_tap #(.CHAN(2'd1)) tap_ocl (
    .clk(clk), .i_rst(i_rst),
    .i_mode_record(mode_record), .i_mode_replay(mode_replay),
    .i_sh_valid(i_sh_valid[1]), .i_sh_addr(i_sh_addr[1]), .i_sh_data(i_sh_data[1]),
    .i_rep_valid(rep_valid[1]), .i_rep_addr(rep_addr[1]), .i_rep_data(rep_data[1]),
    .i_pop(pop[1]),
    .o_cl_valid(o_cl_valid[1]), .o_cl_addr(o_cl_addr[1]), .o_cl_data(o_cl_data[1]),
    .o_empty(fifo_empty[1]), .o_head(fifo_head[1]), .o_overflow(overflow[1])
  );

  rr_channel_tap #(.CHAN(2'd2)) tap_bar1 (
    .clk(clk), .i_rst(i_rst),
    .i_mode_record(mode_record), .i_mode_replay(mode_replay),
    .i_sh_valid(i_sh_valid[2]), .i_sh_addr(i_sh_addr[2]), .i_sh_data(i_sh_data[2]),
    .i_rep_valid(rep_valid[2]), .i_rep_addr(rep_addr[2]), .i_rep_data(rep_data[2]),
    .i_pop(pop[2]),
    .o_cl_valid(o_cl_valid[2]), .o_cl_addr(o_cl_addr[2]), .o_cl_data(o_cl_data[2]),
    .o_empty(fifo_empty[2]), .o_head(fifo_head[2]), .o_overflow(overflow[2])
  );

  //////////////////////////////////////////////////////////////
  // Record merge and replay steering
  //////////////////////////////////////////////////////////////

  rr_log_merge log_merge (
    .clk(clk), .i_rst(i_rst),
    .i_empty(fifo_empty), .i_head(fifo_head),
    .o_pop(pop), .o_rec_valid(o_rec_valid), .o_rec_entry(o_rec_entry)
  );

  rr_replay_decoder replay_decoder (
    .clk(clk), .i_rst(i_rst),
    .i_rep_valid(i_rep_valid), .i_rep_entry(i_rep_entry),
    .o_valid(rep_valid), .o_addr(rep_addr), .o_data(rep_data)
  );

endmodule

/* src/rr_log_merge.sv */
module rr_log_merge (
  input  logic                                      clk,
  input  logic                                      i_rst,
  input  logic [rr_pkg::NUM_CHANNELS-1:0]           i_empty,
  input  rr_pkg::log_entry_t [rr_pkg::NUM_CHANNELS-1:0] i_head,
  output logic [rr_pkg::NUM_CHANNELS-1:0]           o_pop,
  output logic                                      o_rec_valid,
  output rr_pkg::log_entry_t                        o_rec_entry
);

  // Head of the winning FIFO
  rr_pkg::log_entry_t pick_head;
  logic               pick_any;

  //////////////////////////////////////////////////////////////
  // Fixed-priority pick, channel 0 first
  //////////////////////////////////////////////////////////////

  always_comb begin
    o_pop     = '0;
    pick_head = i_head[0];
    pick_any  = 1'b0;
    for (int i = 0; i < rr_pkg::NUM_CHANNELS; i++) begin
      if (!pick_any && !i_empty[i]) begin
        o_pop[i]  = 1'b1;
        pick_head = i_head[i];
        pick_any  = 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////
  // Record stream register
  //////////////////////////////////////////////////////////////

  // No back-pressure, one entry leaves per popped cycle
  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_rec_valid <= 1'b0;
    end else begin
      o_rec_valid <= pick_any;
    end
  end

  always_ff @(posedge clk) begin
    if (pick_any) begin
      o_rec_entry <= pick_head;
    end
  end

endmodule

/* src/rr_pkg.sv */
package rr_pkg;

  //////////////////////////////////////////////////////////////
  // Channel and transaction widths
  //////////////////////////////////////////////////////////////

  // Tapped AXI-lite write channels: 0 sda, 1 ocl, 2 bar1
  localparam int NUM_CHANNELS = 3;
  // Enough bits to tag every channel
  localparam int CHAN_W = 2;
  localparam int ADDR_W = 16;
  // Shared by transactions and the config port
  localparam int DATA_W = 32;

  typedef logic [CHAN_W-1:0] chan_t;

  // One logged write, also the unit of the replay stream
  // chan sits in the top bits of the 50-bit word
  typedef struct packed {
    chan_t             chan;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } log_entry_t;

  //////////////////////////////////////////////////////////////
  // Record path sizing
  //////////////////////////////////////////////////////////////

  // Entries held per channel before a push is dropped
  localparam int LOG_FIFO_DEPTH = 4;
  // Flops between the mode register and the taps
  localparam int MODE_PIPE_STAGES = 4;

  //////////////////////////////////////////////////////////////
  // Configuration register map
  //////////////////////////////////////////////////////////////

  // Mode register, read/write
  localparam logic [3:0] CFG_MODE_ADDR = 4'h0;
  // Sticky overflow flags, a write clears them
  localparam logic [3:0] CFG_STATUS_ADDR = 4'h4;
  // Record entry count, read only
  localparam logic [3:0] CFG_COUNT_ADDR = 4'h8;

  // Bit positions inside the mode register
  localparam int MODE_RECORD_BIT = 0;
  localparam int MODE_REPLAY_BIT = 1;

endpackage

/* src/rr_replay_decoder.sv */
module rr_replay_decoder (
  input  logic                      clk,
  input  logic                      i_rst,
  input  logic                      i_rep_valid,
  input  rr_pkg::log_entry_t        i_rep_entry,
  output logic [rr_pkg::NUM_CHANNELS-1:0] o_valid,
  output logic [rr_pkg::NUM_CHANNELS-1:0][rr_pkg::ADDR_W-1:0] o_addr,
  output logic [rr_pkg::NUM_CHANNELS-1:0][rr_pkg::DATA_W-1:0] o_data
);

  // One payload register shared by all channels
  rr_pkg::log_entry_t entry_q;

  // Unknown tags match no channel and vanish here
  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_valid <= '0;
    end else begin
      for (int i = 0; i < rr_pkg::NUM_CHANNELS; i++) begin
        o_valid[i] <= i_rep_valid && (i_rep_entry.chan == rr_pkg::chan_t'(i));
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_rep_valid) begin
      entry_q <= i_rep_entry;
    end
  end

  // Payload goes everywhere, valid picks the channel
  always_comb begin
    for (int i = 0; i < rr_pkg::NUM_CHANNELS; i++) begin
      o_addr[i] = entry_q.addr;
      o_data[i] = entry_q.data;
    end
  end

endmodule

/* tests/rr_fpgarr_asserts.sv */
module rr_fpgarr_asserts (
  input logic                            clk,
  input logic                            i_rst,
  input logic                            i_cfg_rd,
  input logic                            i_cfg_rvalid,
  input logic [rr_pkg::NUM_CHANNELS-1:0] i_cl_valid,
  input logic [rr_pkg::NUM_CHANNELS-1:0] i_pop,
  input logic [rr_pkg::NUM_CHANNELS-1:0] i_empty
);
  timeunit 1ns;
  timeprecision 1ps;

  // Read response exactly one cycle after the request
  a_rd_resp: assert property (@(posedge clk) disable iff (i_rst) i_cfg_rd |=> i_cfg_rvalid)
    else $error("Config read request got no response one cycle later");
  a_rd_spurious: assert property (@(posedge clk) disable iff (i_rst) !i_cfg_rd |=> !i_cfg_rvalid)
    else $error("Config read response without a request");

  a_cl_known: assert property (@(posedge clk) disable iff (i_rst) !$isunknown(i_cl_valid))
    else $error("Logic-side valid is unknown");

  // Merge pops one FIFO at a time and only one holding data
  a_pop_onehot: assert property (@(posedge clk) disable iff (i_rst) $onehot0(i_pop))
    else $error("More than one FIFO popped in a cycle");
  a_pop_nonempty: assert property (@(posedge clk) disable iff (i_rst) (i_pop & i_empty) == '0)
    else $error("Pop issued to an empty FIFO");

endmodule

bind rr_fpgarr_top rr_fpgarr_asserts asserts (
  .clk(clk), .i_rst(i_rst),
  .i_cfg_rd(i_cfg_rd), .i_cfg_rvalid(o_cfg_rvalid),
  .i_cl_valid(o_cl_valid), .i_pop(pop), .i_empty(fifo_empty)
);

/* tests/tb_rr_fpgarr.sv */
module tb_rr_fpgarr;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NCH = rr_pkg::NUM_CHANNELS;
  localparam int TIMEOUT = 300;

  // Expected logic-side write, stamped with the monitor cycle it must appear in
  typedef struct packed {
    logic [31:0]               stamp;
    logic [rr_pkg::ADDR_W-1:0] addr;
    logic [rr_pkg::DATA_W-1:0] data;
  } cl_exp_t;

  logic clk;
  logic i_rst;
  logic [NCH-1:0] i_sh_valid;
  logic [NCH-1:0][rr_pkg::ADDR_W-1:0] i_sh_addr;
  logic [NCH-1:0][rr_pkg::DATA_W-1:0] i_sh_data;
  logic [NCH-1:0] o_cl_valid;
  logic [NCH-1:0][rr_pkg::ADDR_W-1:0] o_cl_addr;
  logic [NCH-1:0][rr_pkg::DATA_W-1:0] o_cl_data;
  logic o_rec_valid;
  rr_pkg::log_entry_t o_rec_entry;
  logic i_rep_valid;
  rr_pkg::log_entry_t i_rep_entry;
  logic i_cfg_wr;
  logic i_cfg_rd;
  logic [3:0] i_cfg_addr;
  logic [rr_pkg::DATA_W-1:0] i_cfg_wdata;
  logic o_cfg_rvalid;
  logic [rr_pkg::DATA_W-1:0] o_cfg_rdata;

  logic [31:0] lfsr_state = 32'h1ee4;
  // Counts falling edges, outputs are sampled there
  int cyc = 0;
  string test_name = "init";
  // Record stream policy: 0 none allowed, 1 checked, 2 ignored
  int rec_policy = 0;
  cl_exp_t cl_exp [NCH][$];
  rr_pkg::log_entry_t rec_ref [NCH][$];

  rr_fpgarr_top dut (.*);

  always #5 clk = ~clk;

  //////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////

  // Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] r;
    logic fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic check(input string what, input logic [63:0] expected, input logic [63:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("Error: test %s, %s: expected %0h, actual %0h",
                          test_name, what, expected, actual));
    end
  endtask

  task automatic cfg_write(input logic [3:0] addr, input logic [31:0] data);
    @(posedge clk);
    i_cfg_wr    <= 1'b1;
    i_cfg_addr  <= addr;
    i_cfg_wdata <= data;
    @(posedge clk);
    i_cfg_wr <= 1'b0;
  endtask

  // Read one register and compare against the expected value
  task automatic read_expect(input logic [3:0] addr, input logic [31:0] expected, input string what);
    int t;
    @(posedge clk);
    i_cfg_rd   <= 1'b1;
    i_cfg_addr <= addr;
    @(posedge clk);
    i_cfg_rd <= 1'b0;
    for (t = 0; t < TIMEOUT; t++) begin
      @(negedge clk);
      if (o_cfg_rvalid) break;
    end
    if (t == TIMEOUT) abort_run("Timed out waiting for a configuration read response");
    check(what, expected, o_cfg_rdata);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      i_sh_valid  <= '0;
      i_rep_valid <= 1'b0;
    end
  endtask

  // Mode bits need MODE_PIPE_STAGES+1 cycles to reach the taps
  task automatic set_mode(input logic [31:0] mode);
    cfg_write(rr_pkg::CFG_MODE_ADDR, mode);
    idle_cycles(10);
  endtask

  // One cycle of shell strobes, expectations pushed into the models
  task automatic drive_shell(input logic [NCH-1:0] mask, input bit fwd, input bit rec);
    cl_exp_t e;
    rr_pkg::log_entry_t le;
    @(posedge clk);
    for (int ch = 0; ch < NCH; ch++) begin
      e.stamp = cyc + 2;
      e.addr  = lfsr_bits(rr_pkg::ADDR_W);
      e.data  = lfsr_bits(rr_pkg::DATA_W);
      i_sh_valid[ch] <= mask[ch];
      i_sh_addr[ch]  <= e.addr;
      i_sh_data[ch]  <= e.data;
      le = '{chan: rr_pkg::chan_t'(ch), addr: e.addr, data: e.data};
      if (mask[ch] && fwd) cl_exp[ch].push_back(e);
      if (mask[ch] && rec) rec_ref[ch].push_back(le);
    end
  endtask

  // Replay entry plus random shell strobes that must be ignored
  task automatic drive_replay(input rr_pkg::chan_t tag);
    cl_exp_t e;
    @(posedge clk);
    e.stamp = cyc + 3;
    e.addr  = lfsr_bits(rr_pkg::ADDR_W);
    e.data  = lfsr_bits(rr_pkg::DATA_W);
    i_rep_valid <= 1'b1;
    i_rep_entry <= '{chan: tag, addr: e.addr, data: e.data};
    i_sh_valid  <= lfsr_bits(NCH);
    if (tag < NCH) cl_exp[tag].push_back(e);
  endtask

  task automatic wait_models_empty();
    int t;
    int pending;
    for (t = 0; t < TIMEOUT; t++) begin
      @(posedge clk);
      pending = 0;
      for (int ch = 0; ch < NCH; ch++) pending += cl_exp[ch].size() + rec_ref[ch].size();
      if (pending == 0) break;
    end
    if (t == TIMEOUT) abort_run("Timed out waiting for expected outputs to appear");
  endtask

  // Record stream drained once it stays quiet for 8 cycles
  task automatic wait_rec_idle();
    int t;
    int quiet = 0;
    for (t = 0; t < TIMEOUT; t++) begin
      @(negedge clk);
      quiet = o_rec_valid ? 0 : quiet + 1;
      if (quiet == 8) break;
    end
    if (t == TIMEOUT) abort_run("Timed out waiting for the record stream to drain");
  endtask

  //////////////////////////////////////////////////////////////
  // Output monitor, compares every cycle against the models
  //////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    cyc = cyc + 1;
    if (!i_rst) begin
      for (int ch = 0; ch < NCH; ch++) begin
        if (cl_exp[ch].size() > 0 && cl_exp[ch][0].stamp == cyc) begin
          check($sformatf("o_cl_valid[%0d]", ch), 1, o_cl_valid[ch]);
          check($sformatf("o_cl_addr[%0d]", ch), cl_exp[ch][0].addr, o_cl_addr[ch]);
          check($sformatf("o_cl_data[%0d]", ch), cl_exp[ch][0].data, o_cl_data[ch]);
          void'(cl_exp[ch].pop_front());
        end else begin
          check($sformatf("o_cl_valid[%0d]", ch), 0, o_cl_valid[ch]);
        end
      end
      if (o_rec_valid && rec_policy == 0) begin
        abort_run("A record entry appeared while none was expected");
      end else if (o_rec_valid && rec_policy == 1) begin
        if (o_rec_entry.chan >= NCH) abort_run("A record entry carries an invalid channel tag");
        else if (rec_ref[o_rec_entry.chan].size() == 0) abort_run("An extra record entry appeared");
        else check("o_rec_entry", rec_ref[o_rec_entry.chan].pop_front(), o_rec_entry);
      end
    end
  end

  //////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////

  task automatic test_reset();
    test_name = "reset";
    idle_cycles(4);
    read_expect(rr_pkg::CFG_MODE_ADDR, 0, "mode register");
    read_expect(rr_pkg::CFG_STATUS_ADDR, 0, "status register");
    read_expect(rr_pkg::CFG_COUNT_ADDR, 0, "count register");
  endtask

  task automatic test_pass_through();
    test_name = "pass_through";
    repeat (12) drive_shell(lfsr_bits(NCH), 1, 0);
    idle_cycles(1);
    wait_models_empty();
    read_expect(rr_pkg::CFG_COUNT_ADDR, 0, "count register");
  endtask

  task automatic test_record();
    logic [NCH-1:0] mask;
    int n_driven = 0;
    test_name = "record";
    rec_policy = 1;
    set_mode(1 << rr_pkg::MODE_RECORD_BIT);
    // Each burst stays below the FIFO depth per channel
    repeat (4) begin
      drive_shell('1, 1, 1);
      n_driven += NCH;
      repeat (2) begin
        mask = lfsr_bits(NCH);
        drive_shell(mask, 1, 1);
        n_driven += $countones(mask);
      end
      idle_cycles(1);
      wait_models_empty();
    end
    read_expect(rr_pkg::CFG_COUNT_ADDR, n_driven, "count register");
    read_expect(rr_pkg::CFG_STATUS_ADDR, 0, "status register");
    set_mode(0);
  endtask

  task automatic test_overflow();
    logic [31:0] status;
    test_name = "overflow";
    rec_policy = 2;
    set_mode(1 << rr_pkg::MODE_RECORD_BIT);
    // Channel 0 wins every pop, channels 1 and 2 fill up
    repeat (10) drive_shell('1, 1, 0);
    idle_cycles(1);
    wait_models_empty();
    wait_rec_idle();
    @(posedge clk);
    i_cfg_rd   <= 1'b1;
    i_cfg_addr <= rr_pkg::CFG_STATUS_ADDR;
    @(posedge clk);
    i_cfg_rd <= 1'b0;
    @(negedge clk);
    check("status read valid", 1, o_cfg_rvalid);
    status = o_cfg_rdata;
    check("status bit 2", 1, status[2]);
    check("status bit 0", 0, status[0]);
    cfg_write(rr_pkg::CFG_STATUS_ADDR, 0);
    read_expect(rr_pkg::CFG_STATUS_ADDR, 0, "status after clear");
    set_mode(0);
    rec_policy = 0;
  endtask

  task automatic test_replay();
    test_name = "replay";
    set_mode(1 << rr_pkg::MODE_REPLAY_BIT);
    for (int i = 0; i < 12; i++) begin
      drive_replay(rr_pkg::chan_t'(i % NCH));
      // Unknown tag slipped in mid-stream
      if (i == 5) drive_replay(rr_pkg::chan_t'(3));
    end
    idle_cycles(4);
    wait_models_empty();
    set_mode(0);
  endtask

  initial begin
    clk         = 1'b0;
    i_rst       = 1'b1;
    i_sh_valid  = '0;
    i_sh_addr   = '0;
    i_sh_data   = '0;
    i_rep_valid = 1'b0;
    i_rep_entry = '0;
    i_cfg_wr    = 1'b0;
    i_cfg_rd    = 1'b0;
    i_cfg_addr  = '0;
    i_cfg_wdata = '0;
    repeat (5) @(posedge clk);
    i_rst <= 1'b0;
    test_reset();
    test_pass_through();
    test_record();
    test_overflow();
    test_replay();
    $display("** PASS **");
    $finish;
  end

endmodule
